// File: run_sim.sh
#!/bin/sh
# Build and run the processor testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module simple_processor_tb -f simple_processor.f \
  -o simple_processor_sim || exit 1

out=$(./obj_dir/simple_processor_sim)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1

// File: simple_processor.f
+incdir+verilog
verilog/simple_processor_pkg.sv
verilog/ins_dec.sv
verilog/pc_fetch.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/simple_processor.sv
tests/simple_processor_chk.sv
tests/simple_processor_tb.sv

// File: tests/simple_processor_cases.txt
// @00 program: one instruction word per entry
// @80 trace: rd digit then 16-bit data per write, @FE record count, @FF HALT PC
@00
22A8 // 00 LI   r1, 0x2A
4058 // 01 LI   r2, 5
6500 // 02 ADD  r3, r1, r2
8881 // 03 SUB  r4, r2, r1
B082 // 04 AND  r5, r4, r1
C503 // 05 OR   r6, r1, r2
F104 // 06 XOR  r7, r4, r2
6905 // 07 SLL  r3, r2, r2
B106 // 08 SRL  r5, r4, r2
4BD7 // 09 ADDI r2, r2, -3
C207 // 0A ADDI r6, r0, -32
0417 // 0B ADDI r0, r1, 1, write dropped
E100 // 0C ADD  r7, r0, r2
0839 // 0D BNEZ r2, +3, taken
23F8 // 0E LI   r1, 0x3F, skipped
23F8 // 0F LI   r1, 0x3F, skipped
0059 // 10 BNEZ r0, +5, not taken
8785 // 11 SLL  r4, r1, r7
03C9 // 12 BNEZ r0, -4, not taken
000F // 13 NOP
6158 // 14 LI   r3, 0x15
000A // 15 HALT
@80
1002A 20005 3002F 4FFDB 5000A
6002F 7FFDE 300A0 507FE 20002
6FFE0 0002B 70002 400A8 30015
@FE
0F 15

// File: tests/simple_processor_chk.sv
/*
  Wishbone read and retire assertions for the processor top level
  Bound to simple_processor
*/

`timescale 1ns/100ps

`include "simple_processor_settings.svh"

`default_nettype none

module simple_processor_chk (
  input wire logic                      clk_i,
  input wire logic                      rst_n_i,
  input wire logic                      imem_ack_i,
  input wire logic                      imem_cyc_o,
  input wire logic                      imem_stb_o,
  input wire logic                      imem_we_o,
  input wire logic [`IMEM_AW-1:0]       imem_adr_o,
  input wire logic                      halted_o,
  input wire simple_processor_pkg::wb_t retire_o
);

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_stb_o |-> imem_cyc_o)
    else $error("stb high outside cyc");

  a_read_only: assert property (@(posedge clk_i) !imem_we_o) // No write cycles
    else $error("we asserted on read-only port");

  // Wait state holds the request
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_stb_o && !imem_ack_i |=> imem_stb_o && $stable(imem_adr_o))
    else $error("request dropped or address moved during wait");

  a_retire_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    retire_o.valid |-> imem_ack_i)
    else $error("retire without ack");

  a_halt_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halted_o |-> !imem_stb_o)
    else $error("strobe after halt");

endmodule

bind simple_processor simple_processor_chk chk0 (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .imem_ack_i (imem_ack_i),
  .imem_cyc_o (imem_cyc_o),
  .imem_stb_o (imem_stb_o),
  .imem_we_o  (imem_we_o),
  .imem_adr_o (imem_adr_o),
  .halted_o   (halted_o),
  .retire_o   (retire_o)
);

`default_nettype wire

// File: tests/simple_processor_tb.sv
/*
  Testbench for the processor core
  Clock and reset, IMEM model with random wait states,
  retire and fetch-address checks, watchdog
*/

`timescale 1ns/100ps

`include "simple_processor_settings.svh"

`default_nettype none

module simple_processor_tb;

  localparam int CLK_PERIOD = 100;  // ns
  localparam int DRIVE_DLY  = 5;    // Input change after the rising edge
  localparam int MAX_WAIT   = 3;    // IMEM wait states, 0..3
  localparam int TRACE_BASE = 'h80; // Expected retire records
  localparam int TRACE_CNT  = 'hFE; // Number of records
  localparam int HALT_AT    = 'hFF; // PC of the HALT word

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      imem_ack;
  logic [`INSTR_WIDTH-1:0]   imem_dat;
  logic                      imem_cyc;
  logic                      imem_stb;
  logic                      imem_we;
  logic [`IMEM_AW-1:0]       imem_adr;
  logic                      halted;
  simple_processor_pkg::wb_t retire;

  logic [19:0]            cases_mem [256];      // Program, trace, count, HALT PC
  logic [`DATA_WIDTH-1:0] shadow [`REG_COUNT];  // Registers as the trace says
  logic [`IMEM_AW-1:0]    expect_pc;
  logic [31:0]            rng_state;
  int                     wait_left;
  int                     trace_idx;
  int                     error_count;
  int                     tests_failed;
  int                     mark;                 // Error count at test start

  simple_processor dut0 (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .imem_ack_i (imem_ack),
    .imem_dat_i (imem_dat),
    .imem_cyc_o (imem_cyc),
    .imem_stb_o (imem_stb),
    .imem_we_o  (imem_we),
    .imem_adr_o (imem_adr),
    .halted_o   (halted),
    .retire_o   (retire)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic pick_wait();
    rng_state = xorshift32(rng_state);
    wait_left = int'(rng_state % (MAX_WAIT + 1));
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    if (error_count == mark) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, error_count - mark);
      tests_failed++;
    end
    mark = error_count;
  endtask

  // ALU and immediate ops write rd
  function automatic logic writes_reg(input logic [3:0] func);
    case (func)
      simple_processor_pkg::FN_ADD, simple_processor_pkg::FN_SUB,
      simple_processor_pkg::FN_AND, simple_processor_pkg::FN_OR,
      simple_processor_pkg::FN_XOR, simple_processor_pkg::FN_SLL,
      simple_processor_pkg::FN_SRL, simple_processor_pkg::FN_ADDI,
      simple_processor_pkg::FN_LI: return 1'b1;
      default:                     return 1'b0;
    endcase
  endfunction

  // IMEM slave, ack after the chosen number of wait cycles
  task automatic drive_imem();
    if (imem_stb && wait_left == 0) begin
      imem_ack = 1'b1;
      imem_dat = cases_mem[imem_adr][15:0];
    end else begin
      imem_ack = 1'b0;
      imem_dat = rng_state[15:0]; // Junk, ignored without ack
      if (imem_stb) begin
        wait_left--;
      end
    end
  endtask

  // Mid-cycle check of retire port and fetch order
  task automatic sample_cycle();
    logic [15:0]         word;
    logic [3:0]          func;
    logic [19:0]         exp_rec;
    logic [`IMEM_AW-1:0] offset;
    word    = imem_dat;
    func    = word[3:0];
    offset  = {{(`IMEM_AW-6){word[9]}}, word[9:4]};
    exp_rec = cases_mem[TRACE_BASE + trace_idx];
    check_equal(32'(imem_we), 32'd0, "we on read port");
    if (!imem_ack) begin
      check_equal(32'(retire.valid), 32'd0, "retire without ack");
    end else begin
      check_equal(32'(imem_adr), 32'(expect_pc), "fetch address");
      if (writes_reg(func)) begin
        check_equal(32'(trace_idx < cases_mem[TRACE_CNT]), 32'd1, "record beyond trace");
        check_equal(32'(retire.valid), 32'd1, "retire valid");
        check_equal(32'(retire.rd), 32'(exp_rec[18:16]), "retire rd");
        check_equal(32'(retire.data), 32'(exp_rec[15:0]), "retire data");
        if (exp_rec[18:16] != 3'd0) begin
          shadow[exp_rec[18:16]] = exp_rec[15:0]; // r0 keeps reading zero
        end
        trace_idx++;
      end else begin
        check_equal(32'(retire.valid), 32'd0, "retire on non-writing op");
      end
      if (func == simple_processor_pkg::FN_BNEZ && shadow[word[12:10]] != '0) begin
        expect_pc = expect_pc + offset;    // Taken, PC relative
      end else begin
        expect_pc = expect_pc + 8'd1;
      end
      if (func == simple_processor_pkg::FN_HALT) begin
        check_equal(32'(imem_adr), 32'(cases_mem[HALT_AT]), "HALT address");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    imem_ack     = 1'b0;
    imem_dat     = '0;
    rng_state    = 32'h275e_4ca0;
    error_count  = 0;
    tests_failed = 0;
    mark         = 0;
    trace_idx    = 0;
    wait_left    = 0;
    expect_pc    = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      shadow[i] = '0;
    end
    $readmemh("tests/simple_processor_cases.txt", cases_mem);

    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    check_equal(32'(imem_cyc), 32'd0, "cyc in reset");
    check_equal(32'(imem_stb), 32'd0, "stb in reset");
    check_equal(32'(halted), 32'd0, "halted in reset");
    rst_n = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    check_equal(32'(imem_cyc), 32'd1, "cyc after reset");
    check_equal(32'(imem_stb), 32'd1, "stb after reset");
    check_equal(32'(imem_adr), 32'd0, "first strobe address");
    finish_test("reset and first strobe");

    pick_wait();
    while (!halted) begin
      drive_imem();
      @(negedge clk);
      sample_cycle();
      @(posedge clk);
      #DRIVE_DLY;
      if (imem_ack) begin
        pick_wait(); // New bus cycle
      end
    end
    imem_ack = 1'b0;
    check_equal(32'(trace_idx), 32'(cases_mem[TRACE_CNT]), "retire record count");
    finish_test("retire trace and fetch order");

    check_equal(32'(imem_adr), 32'(cases_mem[HALT_AT]), "PC after HALT");
    repeat (5) begin
      @(posedge clk);
      #DRIVE_DLY;
      check_equal(32'(imem_stb), 32'd0, "stb after HALT");
      check_equal(32'(imem_cyc), 32'd0, "cyc after HALT");
      check_equal(32'(halted), 32'd1, "halted held");
    end
    finish_test("halt");

    $display("Tests run: 3, failed: %0d, errors: %0d", tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Every fetch at most MAX_WAIT+1 cycles, plus margin
  initial begin
    int limit_cycles;
    wait (rst_n === 1'b1);
    limit_cycles = (int'(cases_mem[HALT_AT]) + 1) * (MAX_WAIT + 1) + 20;
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: HALT not reached within %0d cycles", limit_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
/*
  ALU
  Function code execution, immediate extension, BNEZ condition
*/

`timescale 1ns/100ps

`include "simple_processor_settings.svh"

`default_nettype none

module alu (
  input  wire simple_processor_pkg::dec_t dec_i,
  input  wire logic [`DATA_WIDTH-1:0]     rs1_data_i,
  input  wire logic [`DATA_WIDTH-1:0]     rs2_data_i,
  output logic [`DATA_WIDTH-1:0]          result_o,       // Write-back data
  output logic                            branch_taken_o
);

  localparam int IMM_W = simple_processor_pkg::IMM_W;
  localparam int SH_W  = $clog2(`DATA_WIDTH); // 4 bits for 16-bit data

  logic [`DATA_WIDTH-1:0] imm_sext;
  logic [`DATA_WIDTH-1:0] imm_zext;
  logic [SH_W-1:0]        shamt;

  ////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////

  assign imm_sext = {{(`DATA_WIDTH-IMM_W){dec_i.imm[IMM_W-1]}}, dec_i.imm}; // ADDI
  assign imm_zext = {{(`DATA_WIDTH-IMM_W){1'b0}}, dec_i.imm};               // LI
  assign shamt    = rs2_data_i[SH_W-1:0]; // Low bits of source 2

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (dec_i.func)
      simple_processor_pkg::FN_ADD:  result_o = rs1_data_i + rs2_data_i;
      simple_processor_pkg::FN_SUB:  result_o = rs1_data_i - rs2_data_i;
      simple_processor_pkg::FN_AND:  result_o = rs1_data_i & rs2_data_i;
      simple_processor_pkg::FN_OR:   result_o = rs1_data_i | rs2_data_i;
      simple_processor_pkg::FN_XOR:  result_o = rs1_data_i ^ rs2_data_i;
      simple_processor_pkg::FN_SLL:  result_o = rs1_data_i << shamt;
      simple_processor_pkg::FN_SRL:  result_o = rs1_data_i >> shamt; // Logical
      simple_processor_pkg::FN_ADDI: result_o = rs1_data_i + imm_sext;
      simple_processor_pkg::FN_LI:   result_o = imm_zext;
      default:                       result_o = '0;  // Not written back
    endcase
  end

  // Taken only on an acknowledged BNEZ
  assign branch_taken_o = dec_i.valid &&
                          (dec_i.func == simple_processor_pkg::FN_BNEZ) &&
                          (rs1_data_i != '0);

endmodule

`default_nettype wire

// File: verilog/ins_dec.sv
/*
  Instruction decoder
  Gates the fetched word with ack, splits R and I fields,
  derives the register write enable
*/

`timescale 1ns/100ps

`include "simple_processor_settings.svh"

`default_nettype none

module ins_dec (
  input  wire logic [`INSTR_WIDTH-1:0]  imem_rdata_i, // Word from IMEM
  input  wire logic                     imem_ack_i,   // Word valid this cycle
  output simple_processor_pkg::dec_t    dec_o
);

  simple_processor_pkg::instr_u instr;

  // No ack, no instruction
  assign instr = imem_ack_i ? imem_rdata_i : '0;

  always_comb begin
    dec_o.valid = imem_ack_i;
    dec_o.func  = instr.r.func;
    dec_o.rd    = instr.r.rd;
    dec_o.rs1   = instr.r.rs1;
    dec_o.rs2   = instr.r.rs2;  // R view
    dec_o.imm   = instr.i.imm;  // I view of the same bits

    // Writers: ALU ops and the two immediate forms
    case (instr.r.func)
      simple_processor_pkg::FN_ADD,
      simple_processor_pkg::FN_SUB,
      simple_processor_pkg::FN_AND,
      simple_processor_pkg::FN_OR,
      simple_processor_pkg::FN_XOR,
      simple_processor_pkg::FN_SLL,
      simple_processor_pkg::FN_SRL,
      simple_processor_pkg::FN_ADDI,
      simple_processor_pkg::FN_LI:   dec_o.we = imem_ack_i; // Zeroed word decodes as ADD
      default:                       dec_o.we = 1'b0;       // BNEZ, HALT, NOP
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/pc_fetch.sv
/*
  Program counter and instruction fetch
  Wishbone classic read master, branch target select, halt state
*/

`timescale 1ns/100ps

`include "simple_processor_settings.svh"

`default_nettype none

module pc_fetch (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire logic                       imem_ack_i,
  input  wire simple_processor_pkg::dec_t dec_i,
  input  wire logic                       branch_taken_i, // From ALU
  output logic                            imem_cyc_o,
  output logic                            imem_stb_o,
  output logic                            imem_we_o,
  output logic [`IMEM_AW-1:0]             imem_adr_o,
  output logic                            halted_o
);

  localparam int IMM_W = simple_processor_pkg::IMM_W;

  logic [`IMEM_AW-1:0] pc;
  logic [`IMEM_AW-1:0] pc_next;
  logic [`IMEM_AW-1:0] br_off;   // Sign-extended branch offset
  logic                active;   // Read cycle open
  logic                halted;
  logic                ack_fire; // stb and ack both high
  logic                halt_hit;

  ////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////

  assign ack_fire = active & imem_ack_i;
  assign halt_hit = ack_fire & dec_i.valid &
                    (dec_i.func == simple_processor_pkg::FN_HALT);

  assign br_off  = {{(`IMEM_AW-IMM_W){dec_i.imm[IMM_W-1]}}, dec_i.imm};
  assign pc_next = branch_taken_i ? pc + br_off : pc + 1'b1;

  ////////////////////////////////////////////////////////////
  // Fetch state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc     <= '0;
      active <= 1'b0;
      halted <= 1'b0;
    end else if (halt_hit) begin
      active <= 1'b0;  // Bus closed for good
      halted <= 1'b1;  // PC left on the HALT word
    end else begin
      active <= ~halted; // Opens one cycle after reset release
      if (ack_fire) begin
        pc <= pc_next;
      end
    end
  end

  // Read-only master, cyc and stb move together
  assign imem_cyc_o = active;
  assign imem_stb_o = active;
  assign imem_we_o  = 1'b0;
  assign imem_adr_o = pc;
  assign halted_o   = halted;

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
/*
  Register file
  Eight registers, r0 reads zero, two async reads, one write
*/

`timescale 1ns/100ps

`include "simple_processor_settings.svh"

`default_nettype none

module reg_file (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  input  wire simple_processor_pkg::reg_addr_t rs1_addr_i,
  input  wire simple_processor_pkg::reg_addr_t rs2_addr_i,
  input  wire simple_processor_pkg::wb_t       wb_i,      // Retire record as write port
  output logic [`DATA_WIDTH-1:0]               rs1_data_o,
  output logic [`DATA_WIDTH-1:0]               rs2_data_o
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // Write at the ack edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && (wb_i.rd != '0)) begin
      regs[wb_i.rd] <= wb_i.data; // r0 write dropped, still shows on retire
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  // r0 forced to zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: verilog/simple_processor.sv
/*
  Processor top level
  Fetch, decode, register file and ALU, retire port
*/

`timescale 1ns/100ps

`include "simple_processor_settings.svh"

`default_nettype none

module simple_processor (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  // Wishbone classic read, IMEM
  input  wire logic                    imem_ack_i,
  input  wire logic [`INSTR_WIDTH-1:0] imem_dat_i,
  output logic                         imem_cyc_o,
  output logic                         imem_stb_o,
  output logic                         imem_we_o,
  output logic [`IMEM_AW-1:0]          imem_adr_o,
  output logic                         halted_o,
  output simple_processor_pkg::wb_t    retire_o   // One record per register write
);

  simple_processor_pkg::dec_t dec;
  simple_processor_pkg::wb_t  retire;
  logic [`DATA_WIDTH-1:0]     rs1_data;
  logic [`DATA_WIDTH-1:0]     rs2_data;
  logic [`DATA_WIDTH-1:0]     alu_result;
  logic                       branch_taken;

  pc_fetch u_pc_fetch (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .imem_ack_i     (imem_ack_i),
    .dec_i          (dec),
    .branch_taken_i (branch_taken),
    .imem_cyc_o     (imem_cyc_o),
    .imem_stb_o     (imem_stb_o),
    .imem_we_o      (imem_we_o),
    .imem_adr_o     (imem_adr_o),
    .halted_o       (halted_o)
  );

  ins_dec u_ins_dec (
    .imem_rdata_i (imem_dat_i),
    .imem_ack_i   (imem_ack_i),
    .dec_o        (dec)
  );

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (dec.rs1),
    .rs2_addr_i (dec.rs2),
    .wb_i       (retire),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  alu u_alu (
    .dec_i          (dec),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .result_o       (alu_result),
    .branch_taken_o (branch_taken)
  );

  // Retire record, same cycle as ack
  assign retire.valid = dec.we;
  assign retire.rd    = dec.rd;
  assign retire.data  = alu_result;
  assign retire_o     = retire;

endmodule

`default_nettype wire

// File: verilog/simple_processor_pkg.sv
/*
  Shared types of the processor core
  Function code enum, R/I instruction union,
  decoded instruction and retire record
*/

`include "simple_processor_settings.svh"

`default_nettype none

package simple_processor_pkg;

  localparam int REG_AW = $clog2(`REG_COUNT); // Register index bits
  localparam int IMM_W  = 6;                  // I form immediate, bits 9..4

  typedef logic [REG_AW-1:0] reg_addr_t;

  // Function codes in bits 3..0, unlisted codes act as NOP
  typedef enum logic [3:0] {
    FN_ADD  = 4'h0,
    FN_SUB  = 4'h1,
    FN_AND  = 4'h2,
    FN_OR   = 4'h3,
    FN_XOR  = 4'h4,
    FN_SLL  = 4'h5,
    FN_SRL  = 4'h6,
    FN_ADDI = 4'h7, // Sign-extended imm
    FN_LI   = 4'h8, // Zero-extended imm
    FN_BNEZ = 4'h9, // PC relative on rs1 != 0
    FN_HALT = 4'hA,
    FN_NOP  = 4'hF
  } func_t;

  // One word, two views
  typedef union packed {
    struct packed {
      reg_addr_t   rd;     // 15..13
      reg_addr_t   rs1;    // 12..10
      reg_addr_t   rs2;    // 9..7
      logic [2:0]  unused; // 6..4
      func_t       func;   // 3..0
    } r;
    struct packed {
      reg_addr_t        rd;
      reg_addr_t        rs1;
      logic [IMM_W-1:0] imm; // 9..4
      func_t            func;
    } i;
  } instr_u;

  typedef struct packed {
    logic             valid; // Word acknowledged this cycle
    func_t            func;
    reg_addr_t        rd;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    logic [IMM_W-1:0] imm;
    logic             we;    // Writes rd, already qualified by valid
  } dec_t;

  // Retire record, also the register file write port
  typedef struct packed {
    logic                   valid;
    reg_addr_t              rd;
    logic [`DATA_WIDTH-1:0] data;
  } wb_t;

endpackage

`default_nettype wire

// File: verilog/simple_processor_settings.svh
/*
  Sizing macros for the processor core
  Data path and instruction widths, register count, IMEM word address
*/

`ifndef SIMPLE_PROCESSOR_SETTINGS_SVH
`define SIMPLE_PROCESSOR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

`define DATA_WIDTH  16 // Register and ALU width
`define INSTR_WIDTH 16 // One instruction per IMEM word

////////////////////////////////////////////////////////////
// Storage
////////////////////////////////////////////////////////////

`define REG_COUNT   8  // r0 hardwired to zero
`define IMEM_AW     8  // IMEM word address bits, 256 words

`endif
